//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_dds_scope
FILELIST = vlog.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dds_sample_source.sv
`timescale 1ns/100ps
`default_nettype none

module dds_sample_source (
   input  wire logic                  CLK_25MHZ,
   input  wire logic                  reset_from_key,
   input  wire scope_pkg::held_keys_t held,
   output logic                       push,
   output scope_pkg::sample_t         push_data
);

   import scope_pkg::*;

   logic [TICK_W-1:0]   tick_cnt;
   logic [LFSR_W-1:0]   lfsr;
   logic [PHASE_W-1:0]  phase;
   logic [PHASE_W-1:0]  phase_step;
   logic [1:0]          wave_sel;
   logic [DEC_W-1:0]    dec_cnt;
   logic [SAMPLE_W-1:0] phase_top;
   logic [SAMPLE_W-2:0] fold;
   sample_t             wave_val;
   sample_t             sample_r;

   assign phase_top  = phase[PHASE_W-1 -: SAMPLE_W];
   assign phase_step = held.key_m ? PHASE_W'(DDS_PHASE_INC / 2) : PHASE_W'(DDS_PHASE_INC);
   assign fold       = phase_top[SAMPLE_W-1] ? ~phase_top[SAMPLE_W-2:0] : phase_top[SAMPLE_W-2:0];

   //////////////////////////////////////////////////
   // tick divider, lfsr and gated phase accumulator
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt <= '0;
         lfsr     <= LFSR_W'(1);
         phase    <= '0;
         dec_cnt  <= '0;
      end
      else
      begin
         if (tick_cnt == TICK_W'(LFSR_TICK_DIV - 1))
         begin
            tick_cnt <= '0;
            lfsr     <= {lfsr[LFSR_W-2:0], lfsr[4] ^ lfsr[2]};  // x^5 + x^3 + 1
         end
         else
         begin
            tick_cnt <= tick_cnt + TICK_W'(1);
         end
         if (lfsr[0])
            phase <= phase + phase_step;                         // lfsr gates the dds
         if (dec_cnt == DEC_W'(SAMPLE_DIV - 1))
            dec_cnt <= '0;
         else
            dec_cnt <= dec_cnt + DEC_W'(1);
      end
   end

   // key 1 wins over 2, 2 over 3, and so on
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         wave_sel <= WAVE_SAW;
      else if (held.key_1)
         wave_sel <= WAVE_SAW;
      else if (held.key_2)
         wave_sel <= WAVE_SQUARE;
      else if (held.key_3)
         wave_sel <= WAVE_TRI;
      else if (held.key_4)
         wave_sel <= WAVE_NOISE;
      else
         wave_sel <= WAVE_SAW;
   end

   always_comb
   begin
      case (wave_sel)
         WAVE_SQUARE: wave_val = phase_top[SAMPLE_W-1] ? sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}})
                                                        : sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});
         WAVE_TRI:    wave_val = sample_t'({~fold[SAMPLE_W-2], fold[SAMPLE_W-3:0], 1'b0});
         WAVE_NOISE:  wave_val = sample_t'({lfsr, {(SAMPLE_W-LFSR_W){1'b0}}});
         default:     wave_val = sample_t'(phase_top);          // sawtooth
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      sample_r <= wave_val;
   end

   assign push      = (dec_cnt == DEC_W'(SAMPLE_DIV - 1));   // one pulse per decimation period
   assign push_data = sample_r;

   a_lfsr_alive : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != '0
   )
   else $error("lfsr locked up at zero");

endmodule

`default_nettype wire

//--- dds_scope_top.sv
`timescale 1ns/100ps
`default_nettype none

module dds_scope_top (
   input  wire logic                  CLK_25MHZ,
   input  wire logic                  reset_from_key,
   input  wire scope_pkg::kbd_event_t kbd_event,
   input  wire logic                  col_strobe,
   output scope_pkg::trace_t          trace,
   output logic                       trace_miss,
   output logic                       fifo_overflow,
   output scope_pkg::held_keys_t      held
);

   import scope_pkg::*;

   logic    push;      // decimated sample strobe
   sample_t push_data;
   logic    pop;
   sample_t head;
   logic    empty;

   //////////////////////////////////////////////////
   // keyboard, source, buffer, display side
   key_hold_tracker u_keys (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_event      (kbd_event),
      .held           (held)
   );

   dds_sample_source u_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .held           (held),
      .push           (push),
      .push_data      (push_data)
   );

   sample_fifo u_fifo (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .push           (push),
      .push_data      (push_data),
      .pop            (pop),
      .head           (head),
      .empty          (empty),
      .fifo_overflow  (fifo_overflow)
   );

   trace_renderer u_render (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .col_strobe     (col_strobe),
      .head           (head),
      .empty          (empty),
      .pop            (pop),
      .trace          (trace),
      .trace_miss     (trace_miss)
   );

endmodule

`default_nettype wire

//--- key_hold_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module key_hold_tracker (
   input  wire logic                  CLK_25MHZ,
   input  wire logic                  reset_from_key,
   input  wire scope_pkg::kbd_event_t kbd_event,
   output scope_pkg::held_keys_t      held
);

   import scope_pkg::*;

   logic [$bits(held_keys_t)-1:0] make_hit;   // same bit order as held_keys_t
   logic [$bits(held_keys_t)-1:0] break_hit;
   logic [$bits(held_keys_t)-1:0] held_bits;

   assign held_bits = held;

   //////////////////////////////////////////////////
   // decode the event byte against the key table
   always_comb
   begin
      make_hit = {
         kbd_event.code == SC_MAKE_1,
         kbd_event.code == SC_MAKE_2,
         kbd_event.code == SC_MAKE_3,
         kbd_event.code == SC_MAKE_4,
         kbd_event.code == SC_MAKE_M
      };
      break_hit = {
         kbd_event.code == SC_BREAK_1,
         kbd_event.code == SC_BREAK_2,
         kbd_event.code == SC_BREAK_3,
         kbd_event.code == SC_BREAK_4,
         kbd_event.code == SC_BREAK_M
      };
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held <= '0;
      end
      else if (kbd_event.ready)
      begin
         held <= held_keys_t'((held_bits | make_hit) & ~break_hit);  // unknown codes fall through
      end
   end

   // a code listed as both make and break would leave the key state ambiguous
   a_code_unique : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      kbd_event.ready |-> !((|make_hit) && (|break_hit))
   )
   else $error("event code %h matches a make and a break entry", kbd_event.code);

endmodule

`default_nettype wire

//--- sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sample_fifo (
   input  wire logic               CLK_25MHZ,
   input  wire logic               reset_from_key,
   input  wire logic               push,
   input  wire scope_pkg::sample_t push_data,
   input  wire logic               pop,
   output scope_pkg::sample_t      head,
   output logic                    empty,
   output logic                    fifo_overflow
);

   import scope_pkg::*;

   sample_t          mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_write;
   logic             do_read;

   assign full     = (count == CNT_W'(FIFO_DEPTH));
   assign empty    = (count == '0);
   assign head     = mem[rd_ptr];                 // show-ahead
   assign do_read  = pop && !empty;
   assign do_write = push && (!full || do_read);  // a pop frees the slot in the same cycle

   always_ff @(posedge CLK_25MHZ)
   begin
      if (do_write)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         fifo_overflow <= 1'b0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + PTR_W'(1);
         if (do_read)
            rd_ptr <= rd_ptr + PTR_W'(1);
         case ({do_write, do_read})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
         if (push && !do_write)
            fifo_overflow <= 1'b1;               // sticky until reset
      end
   end

   a_count_bound : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      count <= CNT_W'(FIFO_DEPTH)
   )
   else $error("fifo count %0d above depth", count);

   // the renderer must look at empty before it pops
   a_no_pop_empty : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      pop |-> !empty
   )
   else $error("pop on empty fifo");

endmodule

`default_nettype wire

//--- scope_pkg.sv
`default_nettype none

package scope_pkg;

   //////////////////////////////////////////////////
   // widths and timing
   localparam int SAMPLE_W      = 12;
   localparam int PHASE_W       = 32;
   localparam int LFSR_W        = 5;
   localparam int DDS_PHASE_INC = 258;
   localparam int LFSR_TICK_DIV = 25;   // 25 MHz down to the old 1 MHz step rate
   localparam int SAMPLE_DIV    = 64;
   localparam int FIFO_DEPTH    = 16;
   localparam int PLOT_ROW_BASE = 266;  // top row of the trace window
   localparam int ROW_W         = 11;

   localparam int TICK_W = $clog2(LFSR_TICK_DIV);
   localparam int DEC_W  = $clog2(SAMPLE_DIV);
   localparam int PTR_W  = $clog2(FIFO_DEPTH);
   localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);  // must hold FIFO_DEPTH itself

   localparam logic [1:0] WAVE_SAW    = 2'd0;
   localparam logic [1:0] WAVE_SQUARE = 2'd1;
   localparam logic [1:0] WAVE_TRI    = 2'd2;
   localparam logic [1:0] WAVE_NOISE  = 2'd3;

   //////////////////////////////////////////////////
   // keyboard event bytes, break is make with bit 7 set
   localparam logic [7:0] SC_MAKE_1  = 8'h16;
   localparam logic [7:0] SC_MAKE_2  = 8'h1E;
   localparam logic [7:0] SC_MAKE_3  = 8'h26;
   localparam logic [7:0] SC_MAKE_4  = 8'h25;
   localparam logic [7:0] SC_MAKE_M  = 8'h3A;
   localparam logic [7:0] SC_BREAK_1 = 8'h96;
   localparam logic [7:0] SC_BREAK_2 = 8'h9E;
   localparam logic [7:0] SC_BREAK_3 = 8'hA6;
   localparam logic [7:0] SC_BREAK_4 = 8'hA5;
   localparam logic [7:0] SC_BREAK_M = 8'hBA;

   typedef struct packed {
      logic       ready;  // one-cycle strobe
      logic [7:0] code;
   } kbd_event_t;

   typedef struct packed {
      logic key_1;
      logic key_2;
      logic key_3;
      logic key_4;
      logic key_m;
   } held_keys_t;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   typedef struct packed {
      logic [ROW_W-1:0] row;
      logic             valid;
   } trace_t;

endpackage

`default_nettype wire

//--- tb_dds_scope.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dds_scope;

   import scope_pkg::*;

   localparam int CYCLE_LIMIT = 20000;  // the full run takes about 14000
   localparam logic [7:0] MAKE_CODES [5] = '{SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_M};
   localparam logic [7:0] BREAK_CODES [5] = '{SC_BREAK_1, SC_BREAK_2, SC_BREAK_3, SC_BREAK_4,
                                               SC_BREAK_M};
   localparam logic [7:0] OTHER_MAKE  = 8'h1C;  // a key with no held bit
   localparam logic [7:0] OTHER_BREAK = 8'h9C;
   localparam int         WAVE_COLS   = 32;

   logic       CLK_25MHZ;
   logic       reset_from_key;
   kbd_event_t kbd_event;
   logic       col_strobe;
   trace_t     trace;
   logic       trace_miss;
   logic       fifo_overflow;
   held_keys_t held;

   int n_mismatch = 0;
   int n_other    = 0;
   int cycle_cnt  = 0;

   int   n_valid_seen  = 0;
   int   n_miss_seen   = 0;
   logic overflow_seen = 1'b0;

   // cycle model state, reset values
   held_keys_t  m_held     = '0;
   int          m_tick     = 0;
   logic [4:0]  m_lfsr     = 5'd1;
   logic [31:0] m_phase    = '0;
   int          m_dec      = 0;
   int          m_wave     = 0;  // 0 saw, 1 square, 2 triangle, 3 noise
   sample_t     m_sample   = '0;
   sample_t     m_fifo [$];
   logic        m_overflow = 1'b0;
   logic        m_valid    = 1'b0;
   logic        m_miss     = 1'b0;
   int          m_row      = 0;

   dds_scope_top uut (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_event      (kbd_event),
      .col_strobe     (col_strobe),
      .trace          (trace),
      .trace_miss     (trace_miss),
      .fifo_overflow  (fifo_overflow),
      .held           (held)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;  // 25 MHz
   end

   //////////////////////////////////////////////////
   // reference model
   function automatic sample_t expected_wave(input logic [31:0] phase, input int wave,
                                             input logic [4:0] lfsr);
      int top;
      int fold;
      int v;
      top = int'(phase[31:20]);
      case (wave)
         1: v = (top >= 2048) ? -2048 : 2047;
         2:
         begin
            fold = (top >= 2048) ? 4095 - top : top;  // mirror the upper half
            v    = 2 * fold - 2048;
         end
         3: v = int'(lfsr) * 128;
         default: v = top;
      endcase
      if (v >= 2048)
         v = v - 4096;
      return v[11:0];
   endfunction

   function automatic int plot_row(input sample_t s);
      return PLOT_ROW_BASE + 255 - (int'(s) + 2048) / 16;  // offset binary, top 8 bits
   endfunction

   function automatic int select_wave(input held_keys_t h);
      if (h.key_1)
         return 0;
      else if (h.key_2)
         return 1;
      else if (h.key_3)
         return 2;
      else if (h.key_4)
         return 3;
      return 0;
   endfunction

   function automatic held_keys_t apply_key(input held_keys_t h, input logic [7:0] code);
      held_keys_t n;
      n = h;
      case (code)
         SC_MAKE_1:  n.key_1 = 1'b1;
         SC_MAKE_2:  n.key_2 = 1'b1;
         SC_MAKE_3:  n.key_3 = 1'b1;
         SC_MAKE_4:  n.key_4 = 1'b1;
         SC_MAKE_M:  n.key_m = 1'b1;
         SC_BREAK_1: n.key_1 = 1'b0;
         SC_BREAK_2: n.key_2 = 1'b0;
         SC_BREAK_3: n.key_3 = 1'b0;
         SC_BREAK_4: n.key_4 = 1'b0;
         SC_BREAK_M: n.key_m = 1'b0;
         default:    n = h;
      endcase
      return n;
   endfunction

   always @(posedge CLK_25MHZ)
   begin : cycle_model
      logic    pop_now;
      sample_t next_sample;
      next_sample = expected_wave(m_phase, m_wave, m_lfsr);
      if (reset_from_key)
      begin
         m_fifo.delete();
         m_sample   = next_sample;
         m_held     = '0;
         m_tick     = 0;
         m_lfsr     = 5'd1;
         m_phase    = '0;
         m_dec      = 0;
         m_wave     = 0;
         m_overflow = 1'b0;
         m_valid    = 1'b0;
         m_miss     = 1'b0;
      end
      else
      begin
         pop_now = col_strobe && (m_fifo.size() != 0);
         m_valid = pop_now;
         m_miss  = col_strobe && (m_fifo.size() == 0);
         if (pop_now)
            m_row = plot_row(m_fifo.pop_front());
         if (m_dec == SAMPLE_DIV - 1)
         begin
            if (m_fifo.size() < FIFO_DEPTH)
               m_fifo.push_back(m_sample);
            else
               m_overflow = 1'b1;  // newest sample lost
         end
         if (m_lfsr[0])
            m_phase = m_phase + (m_held.key_m ? DDS_PHASE_INC / 2 : DDS_PHASE_INC);
         if (m_tick == LFSR_TICK_DIV - 1)
         begin
            m_tick = 0;
            m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
         end
         else
            m_tick = m_tick + 1;
         m_dec    = (m_dec == SAMPLE_DIV - 1) ? 0 : m_dec + 1;
         m_sample = next_sample;
         m_wave   = select_wave(m_held);
         if (kbd_event.ready)
            m_held = apply_key(m_held, kbd_event.code);
      end
   end

   //////////////////////////////////////////////////
   // compare dut outputs with the model
   always @(negedge CLK_25MHZ)
   begin : compare_outputs
      if (!reset_from_key)
      begin
         assert (held === m_held)
         else
         begin
            n_mismatch++;
            $display("mismatch at %0t: held exp %b got %b", $time, m_held, held);
         end
         assert (trace.valid === m_valid)
         else
         begin
            n_mismatch++;
            $display("mismatch at %0t: trace.valid exp %b got %b", $time, m_valid, trace.valid);
         end
         assert (trace_miss === m_miss)
         else
         begin
            n_mismatch++;
            $display("mismatch at %0t: trace_miss exp %b got %b", $time, m_miss, trace_miss);
         end
         assert (fifo_overflow === m_overflow)
         else
         begin
            n_mismatch++;
            $display("mismatch at %0t: fifo_overflow exp %b got %b", $time, m_overflow,
                     fifo_overflow);
         end
         if (m_valid)
         begin
            n_valid_seen++;
            assert (trace.row === ROW_W'(m_row))
            else
            begin
               n_mismatch++;
               $display("mismatch at %0t: trace.row exp %0d got %0d", $time, m_row, trace.row);
            end
         end
         if (m_miss)
            n_miss_seen++;
         if (m_overflow)
            overflow_seen = 1'b1;
      end
   end

   always @(posedge CLK_25MHZ)
   begin : watchdog
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         n_other++;
         $display("timeout: run reached %0d cycles without finishing", CYCLE_LIMIT);
         $display("errors: %0d mismatch, %0d other", n_mismatch, n_other);
         $display("Checks failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // stimulus, driven just after the rising edge
   task automatic next_cycle();
      @(posedge CLK_25MHZ);
      #2;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic send_code(input logic [7:0] code);
      kbd_event = '{ready: 1'b1, code: code};
      next_cycle();
      kbd_event.ready = 1'b0;
   endtask

   task automatic strobe_columns(input int n, input int gap_min, input int gap_max);
      int gap;
      repeat (n)
      begin
         col_strobe = 1'b1;
         next_cycle();
         col_strobe = 1'b0;
         gap = $urandom_range(gap_max, gap_min);
         idle_cycles(gap);
      end
   endtask

   initial
   begin : stimulus
      int order [5];
      int pick;
      int tmp;
      void'($urandom(65378));
      reset_from_key = 1'b1;
      kbd_event      = '0;
      col_strobe     = 1'b0;
      repeat (3) @(posedge CLK_25MHZ);
      #2 reset_from_key = 1'b0;

      strobe_columns(1, 4, 4);  // nothing buffered yet

      // held keys in random order, with a foreign code while one is held
      for (int i = 0; i < 5; i++)
         order[i] = i;
      for (int i = 4; i > 0; i--)
      begin
         pick        = $urandom_range(i, 0);
         tmp         = order[i];
         order[i]    = order[pick];
         order[pick] = tmp;
      end
      for (int i = 0; i < 5; i++)
      begin
         send_code(MAKE_CODES[order[i]]);
         idle_cycles(2);
         send_code(OTHER_MAKE);
         idle_cycles(2);
         send_code(BREAK_CODES[order[i]]);
         idle_cycles(2);
      end
      send_code(OTHER_BREAK);

      strobe_columns(WAVE_COLS, 50, 90);  // sawtooth
      for (int k = 1; k < 4; k++)
      begin
         send_code(MAKE_CODES[k]);
         strobe_columns(WAVE_COLS, 50, 90);
         send_code(BREAK_CODES[k]);
      end
      send_code(SC_MAKE_M);
      strobe_columns(WAVE_COLS, 50, 90);
      send_code(SC_BREAK_M);

      ////////////////////////////////////////////////
      // starve the display side until the fifo drops samples
      idle_cycles(20 * SAMPLE_DIV);
      strobe_columns(20, 4, 12);
      strobe_columns(8, 50, 90);

      reset_from_key = 1'b1;
      idle_cycles(3);
      reset_from_key = 1'b0;
      strobe_columns(1, 4, 4);

      assert (n_miss_seen > 0)
      else
      begin
         n_other++;
         $display("no column strobe ever found the fifo empty");
      end
      assert (n_valid_seen > 0)
      else
      begin
         n_other++;
         $display("no valid trace was ever produced");
      end
      assert (overflow_seen)
      else
      begin
         n_other++;
         $display("the fifo never overflowed during the starved stretch");
      end

      $display("errors: %0d mismatch, %0d other", n_mismatch, n_other);
      if (n_mismatch == 0 && n_other == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- trace_renderer.sv
`timescale 1ns/100ps
`default_nettype none

module trace_renderer (
   input  wire logic               CLK_25MHZ,
   input  wire logic               reset_from_key,
   input  wire logic               col_strobe,
   input  wire scope_pkg::sample_t head,
   input  wire logic               empty,
   output logic                    pop,
   output scope_pkg::trace_t       trace,
   output logic                    trace_miss
);

   import scope_pkg::*;

   logic [7:0]       plot_byte;
   logic [ROW_W-1:0] row_r;
   logic             valid_r;

   assign pop       = col_strobe && !empty;
   assign plot_byte = {~head[SAMPLE_W-1], head[SAMPLE_W-2 -: 7]};  // offset binary, top 8 bits

   //////////////////////////////////////////////////
   // column strobe to screen row, one cycle
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         valid_r    <= 1'b0;
         trace_miss <= 1'b0;
      end
      else
      begin
         valid_r    <= pop;
         trace_miss <= col_strobe && empty;  // nothing buffered for this column
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (pop)
         row_r <= ROW_W'(PLOT_ROW_BASE + 255) - ROW_W'(plot_byte);  // larger sample, higher on screen
   end

   assign trace = '{row: row_r, valid: valid_r};

   a_valid_or_miss : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      !(trace.valid && trace_miss)
   )
   else $error("trace valid and miss in the same cycle");

endmodule

`default_nettype wire

//--- vlog.f
scope_pkg.sv
key_hold_tracker.sv
dds_sample_source.sv
sample_fifo.sv
trace_renderer.sv
dds_scope_top.sv
tb_dds_scope.sv
